/* hw/int_ack_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zint_cfg.svh"

module int_ack_ctrl
  import zint_pkg::*;
(
  input  wire              clk,
  input  wire              int_start_frm,  // frame sync
  input  wire              zpos,
  input  wire              wait_n,
  input  wire              vdos,
  input  wire              intack,         // CPU interrupt acknowledge
  input  int_req_t         req,
  output int_clr_t         clr,
  output logic [7:0]       im2vect,
  output logic             boost_start
);

  localparam int PW = `ZINT_PULSE_LOG2;

  logic          intack_r;
  logic          ack_s;
  int_src_t      sel_nxt;
  int_src_t      sel_q;

  logic          wait_r;
  logic [PW:0]   pulse_cnt;
  logic          pulse_fin;
  logic          pulse_en;
  logic          fin_r;
  logic          fin_s;

  // acknowledge edge
  always_ff @(posedge clk)
    intack_r <= intack;

  assign ack_s = intack && !intack_r;

  // pick the highest priority pending source
  always_comb
  begin
    if (req.frm)
      sel_nxt = src_frm;
    else if (req.lin)
      sel_nxt = src_lin;
    else if (req.dma)
      sel_nxt = src_dma;
    else
      sel_nxt = sel_q;  // nothing pending, keep last
  end

  always_ff @(posedge clk)
  begin
    if (ack_s)
      sel_q <= sel_nxt;
  end

  always_comb
  begin
    case (sel_q)
      src_frm: im2vect = `ZINT_VECT_FRM;
      src_lin: im2vect = `ZINT_VECT_LIN;
      src_dma: im2vect = `ZINT_VECT_DMA;
      default: im2vect = `ZINT_VECT_NONE;
    endcase
  end

  // wait as seen one cycle late
  always_ff @(posedge clk)
    wait_r <= !wait_n;

  // frame pulse length counter, top bit ends the pulse
  assign pulse_fin = pulse_cnt[PW];
  assign pulse_en  = zpos && !pulse_fin && !wait_r && !vdos;

  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      pulse_cnt <= '0;
    else if (pulse_en)
      pulse_cnt <= pulse_cnt + 1'b1;
  end

  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      fin_r <= 1'b0;
    else
      fin_r <= pulse_fin;
  end

  assign fin_s = pulse_fin && !fin_r;  // timeout edge

  assign clr.ack_s     = ack_s;
  assign clr.pulse_fin = pulse_fin;

  // one pulse per interrupt end, acknowledge or frame timeout
  assign boost_start = `ZINT_BOOST && (ack_s || fin_s);

endmodule

`default_nettype wire

/* hw/int_line_timer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zint_cfg.svh"

module int_line_timer
(
  input  wire              clk,
  input  wire              int_start_frm,  // frame sync
  input  wire              zpos,           // enabled clock phase
  input  logic [8:0]       intline,        // line number for the line INT
  output logic             int_start_lin
);

  localparam int PH_W = $clog2(`ZINT_LINE_TICKS);
  localparam logic [PH_W-1:0] PH_LAST = PH_W'(`ZINT_LINE_TICKS - 1);

  logic [PH_W-1:0]         phase_q;
  logic [`ZINT_LINE_W-1:0] line_q;
  logic [`ZINT_LINE_W-1:0] line_nxt;
  logic                    line_end;
  logic                    lin_hit;
  logic                    lin_strobe_q;

  // last phase of the current raster line
  assign line_end = zpos && (phase_q == PH_LAST);
  assign line_nxt = line_q + 1'b1;

  // line INT fires only when wrapping into the programmed line
  assign lin_hit = line_end && (line_nxt == intline);

  // phase within the line
  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      phase_q <= '0;
    else if (zpos)
    begin
      if (line_end)
        phase_q <= '0;
      else
        phase_q <= phase_q + 1'b1;
    end
  end

  // line within the frame
  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      line_q <= '0;
    else if (line_end)
      line_q <= line_nxt;
  end

  // single cycle start strobe, lines up with line_q == intline
  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      lin_strobe_q <= 1'b0;
    else
      lin_strobe_q <= lin_hit;
  end

  assign int_start_lin = lin_strobe_q;

endmodule

`default_nettype wire

/* hw/int_req_latch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zint_cfg.svh"

module int_req_latch
  import zint_pkg::*;
(
  input  wire              clk,
  input  wire              int_start_frm,  // frame sync, also sets the frame request
  input  wire              res,
  input  logic [7:0]       intmask,
  input  wire              int_start_lin,
  input  wire              int_start_dma,
  input  wire              vdos,           // virtual disk OS active
  input  int_clr_t         clr,
  output int_req_t         req,
  output logic             int_n
);

  // a cleared mask bit kills its flag and blocks new starts
  logic dis_frm;
  logic dis_lin;
  logic dis_dma;

  logic frm_q;
  logic lin_q;
  logic dma_q;

  assign dis_frm = !intmask[`ZINT_MASK_FRM];
  assign dis_lin = !intmask[`ZINT_MASK_LIN];
  assign dis_dma = !intmask[`ZINT_MASK_DMA];

  // frame request, held set for as long as frame sync is high
  always_ff @(posedge clk, posedge int_start_frm)
  begin
    if (int_start_frm)
      frm_q <= 1'b1;
    else if (res || dis_frm)
      frm_q <= 1'b0;
    else if (clr.ack_s || clr.pulse_fin)  // served or timed out
      frm_q <= 1'b0;
  end

  // line request, priority 1
  always_ff @(posedge clk)
  begin
    if (res || dis_lin)
      lin_q <= 1'b0;
    else if (int_start_lin)
      lin_q <= 1'b1;
    else if (clr.ack_s && !frm_q)
      lin_q <= 1'b0;
  end

  // DMA request, priority 2
  // survives vdos since only the output is blocked
  always_ff @(posedge clk)
  begin
    if (res || dis_dma)
      dma_q <= 1'b0;
    else if (int_start_dma)
      dma_q <= 1'b1;
    else if (clr.ack_s && !frm_q && !lin_q)
      dma_q <= 1'b0;
  end

  assign req.frm = frm_q;
  assign req.lin = lin_q;
  assign req.dma = dma_q;

  // active low INT, suppressed while in vdos
  assign int_n = !((frm_q || lin_q || dma_q) && !vdos);

endmodule

`default_nettype wire

/* hw/zint_cfg.svh */
`ifndef ZINT_CFG_SVH
`define ZINT_CFG_SVH

// IM2 vector bytes put on the bus at acknowledge
`define ZINT_VECT_FRM   8'hFF
`define ZINT_VECT_LIN   8'hFD
`define ZINT_VECT_DMA   8'hFB
`define ZINT_VECT_NONE  8'hFF

// frame pulse lasts 2**ZINT_PULSE_LOG2 enabled phases
`define ZINT_PULSE_LOG2 5

// raster geometry
`define ZINT_LINE_TICKS 224
`define ZINT_LINE_W     9

// bit positions in the mask register
`define ZINT_MASK_FRM   0
`define ZINT_MASK_LIN   1
`define ZINT_MASK_DMA   2

// boost start output enable, set to 1'b0 to tie boost_start low
`define ZINT_BOOST      1'b1

`endif

/* hw/zint_pkg.sv */
`default_nettype none

package zint_pkg;

  // interrupt sources, in priority order (0 is served first)
  typedef enum logic [1:0] {
    src_frm  = 2'd0,
    src_lin  = 2'd1,
    src_dma  = 2'd2,
    src_none = 2'd3
  } int_src_t;

  // pending request flags, one per source
  typedef struct packed {
    logic frm;
    logic lin;
    logic dma;
  } int_req_t;

  // clear strobes from the acknowledge side
  typedef struct packed {
    logic ack_s;      // first cycle of intack
    logic pulse_fin;  // frame pulse counter expired
  } int_clr_t;

endpackage

`default_nettype wire

/* hw/zint_top.sv */
`timescale 1ns/100ps
`default_nettype none

module zint_top
  import zint_pkg::*;
(
  input  wire              clk,
  input  wire              int_start_frm,  // frame sync
  input  wire              res,
  input  wire              zpos,
  input  wire              wait_n,
  input  wire              vdos,
  input  wire              intack,
  input  logic [7:0]       intmask,
  input  logic [8:0]       intline,
  input  wire              int_start_dma,
  output logic             int_n,
  output logic [7:0]       im2vect,
  output logic             boost_start
);

  logic     int_start_lin;
  int_req_t req;
  int_clr_t clr;

  // raster line interrupt source
  int_line_timer u_int_line_timer
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .zpos          (zpos),
    .intline       (intline),
    .int_start_lin (int_start_lin)
  );

  int_req_latch u_int_req_latch
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .res           (res),
    .intmask       (intmask),
    .int_start_lin (int_start_lin),
    .int_start_dma (int_start_dma),
    .vdos          (vdos),
    .clr           (clr),
    .req           (req),
    .int_n         (int_n)
  );

  // acknowledge, vector and frame pulse timing
  int_ack_ctrl u_int_ack_ctrl
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .zpos          (zpos),
    .wait_n        (wait_n),
    .vdos          (vdos),
    .intack        (intack),
    .req           (req),
    .clr           (clr),
    .im2vect       (im2vect),
    .boost_start   (boost_start)
  );

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
+incdir+tests
hw/zint_pkg.sv
hw/int_line_timer.sv
hw/int_req_latch.sv
hw/int_ack_ctrl.sv
hw/zint_top.sv
tests/zint_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the interrupt controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module zint_tb -o zint_sim

# the verdict comes from the log, so a failing run must not stop the script here
./obj_dir/zint_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log
then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* tests/zint_tb_cases.svh */
`ifndef ZINT_TB_CASES_SVH
`define ZINT_TB_CASES_SVH

typedef struct packed {
  logic [7:0] mask;
  logic [8:0] line;
  logic       frm;        // one cycle frame sync
  logic       dma;        // one cycle DMA start
  logic       res;        // one cycle synchronous clear
  logic       vdos;
  logic       wait_n;
  logic       ack;        // one cycle intack
  logic [9:0] nz;         // zpos cycles in a row
  logic       exp_int_n;
  logic [7:0] exp_vect;
  logic [1:0] exp_boost;
} row_t;

localparam logic [7:0] M_FRM    = 8'(1 << `ZINT_MASK_FRM);
localparam logic [7:0] M_LIN    = 8'(1 << `ZINT_MASK_LIN);
localparam logic [7:0] M_DMA    = 8'(1 << `ZINT_MASK_DMA);
localparam logic [7:0] M_ALL    = M_FRM | M_LIN | M_DMA;
localparam logic [7:0] M_NO_DMA = M_FRM | M_LIN;
localparam logic [7:0] M_NO_FRM = M_LIN | M_DMA;

localparam int NUM_ROWS = 26;

// stimulus fields then expected int_n, im2vect on ack rows and boost_start pulses
localparam row_t CASES [NUM_ROWS] = '{
  // frame pulse after frame sync counts 20 + 11 + 1 phases
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd20, 1'b0, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 10'd40, 1'b0, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 10'd5, 1'b1, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd11, 1'b0, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd1, 1'b1, 8'h00, 2'd1},
  // DMA raised inside vdos stays pending
  '{M_ALL, 9'd0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 10'd0, 1'b1, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b0, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 10'd0, 1'b1, `ZINT_VECT_DMA, 2'd1},
  // frame sync inside vdos then expiry with no acknowledge
  '{M_ALL, 9'd0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 10'd40, 1'b1, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd32, 1'b1, 8'h00, 2'd1},
  // masking
  '{M_NO_DMA, 9'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b1, 8'h00, 2'd0},
  '{M_NO_FRM, 9'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b1, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b0, 8'h00, 2'd0},
  '{M_NO_DMA, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b1, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b1, 8'h00, 2'd0},
  // res drops frame and DMA together
  '{M_ALL, 9'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b0, 8'h00, 2'd0},
  '{M_ALL, 9'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 10'd0, 1'b1, 8'h00, 2'd0},
  // line 2 is one phase short and then hits the wrap
  '{M_LIN, 9'd2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    10'(2 * `ZINT_LINE_TICKS - 1), 1'b1, 8'h00, 2'd0},
  '{M_LIN, 9'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 10'd1, 1'b0, 8'h00, 2'd0},
  '{M_LIN, 9'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 10'd0, 1'b1, `ZINT_VECT_LIN, 2'd1},
  // all three pending and served in priority order
  '{M_ALL, 9'd1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    10'(`ZINT_LINE_TICKS), 1'b0, 8'h00, 2'd0},
  '{M_ALL, 9'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 10'd0, 1'b0, 8'h00, 2'd0},
  '{M_ALL, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 10'd0, 1'b0, `ZINT_VECT_FRM, 2'd1},
  '{M_ALL, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 10'd0, 1'b0, `ZINT_VECT_LIN, 2'd1},
  '{M_ALL, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 10'd0, 1'b1, `ZINT_VECT_DMA, 2'd1},
  // vector kept with nothing pending
  '{M_ALL, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 10'd0, 1'b1, `ZINT_VECT_DMA, 2'd1}
};

`endif

/* tests/zint_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zint_cfg.svh"

module zint_tb
  import zint_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;
  localparam int ROW_OVH    = 16;  // setup, settle, ack, padding and check cycles

  logic       clk;
  logic       int_start_frm;
  logic       res;
  logic       zpos;
  logic       wait_n;
  logic       vdos;
  logic       intack;
  logic [7:0] intmask;
  logic [8:0] intline;
  logic       int_start_dma;
  logic       int_n;
  logic [7:0] im2vect;
  logic       boost_start;

  `include "zint_tb_cases.svh"

  logic [7:0] lfsr_q;
  int         boost_seen;  // pulses seen in the current row

  zint_top u_dut
  (
    .clk           (clk),
    .int_start_frm (int_start_frm),
    .res           (res),
    .zpos          (zpos),
    .wait_n        (wait_n),
    .vdos          (vdos),
    .intack        (intack),
    .intmask       (intmask),
    .intline       (intline),
    .int_start_dma (int_start_dma),
    .int_n         (int_n),
    .im2vect       (im2vect),
    .boost_start   (boost_start)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // 8 bit Fibonacci LFSR with taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    lfsr_step = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic int max_row_zpos();
    int m;
    m = 0;
    for (int k = 0; k < NUM_ROWS; k++)
    begin
      if (int'(CASES[k].nz) > m)
        m = int'(CASES[k].nz);
    end
    return m;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Error at %0.1f ns: %s is %0h, expected %0h", $realtime, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one clock with boost_start sampled mid cycle
  task automatic one_cycle();
    @(negedge clk);
    if (boost_start === 1'b1)
      boost_seen++;
    @(posedge clk);
  endtask

  // starts right after a rising edge and returns on one
  task automatic run_row(input row_t r, input int idx);
    string      tag;
    logic [1:0] pad;
    tag = $sformatf("row %0d", idx);
    boost_seen = 0;
    intmask       <= r.mask;
    intline       <= r.line;
    vdos          <= r.vdos;
    wait_n        <= r.wait_n;
    int_start_frm <= r.frm;
    int_start_dma <= r.dma;
    res           <= r.res;
    one_cycle();
    int_start_frm <= 1'b0;
    int_start_dma <= 1'b0;
    res           <= 1'b0;
    zpos          <= (r.nz != 10'd0);
    repeat (int'(r.nz)) one_cycle();
    zpos <= 1'b0;
    repeat (2) one_cycle();  // line strobe reaches its flag
    if (r.ack)
    begin
      intack <= 1'b1;
      one_cycle();
      intack <= 1'b0;
      one_cycle();
    end
    // 1 to 4 idle padding cycles
    lfsr_q = lfsr_step(lfsr_q);
    pad[1] = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    pad[0] = lfsr_q[0];
    repeat (int'(pad) + 1) one_cycle();
    @(negedge clk);
    if (boost_start === 1'b1)
      boost_seen++;
    check_eq(32'(int_n), 32'(r.exp_int_n), {tag, " int_n"});
    if (r.ack)
      check_eq(32'(im2vect), 32'(r.exp_vect), {tag, " im2vect"});
    check_eq(32'(boost_seen), 32'(r.exp_boost), {tag, " boost_start pulses"});
    @(posedge clk);
  endtask

  initial
  begin
    clk           = 1'b0;
    int_start_frm = 1'b1;  // frame sync doubles as reset
    res           = 1'b0;
    zpos          = 1'b0;
    wait_n        = 1'b1;
    vdos          = 1'b0;
    intack        = 1'b0;
    intmask       = M_ALL;
    intline       = 9'd0;
    int_start_dma = 1'b0;
    lfsr_q        = 8'd56;
    boost_seen    = 0;

    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_eq(32'(int_n), 32'd0, "int_n during frame sync");
    @(posedge clk);
    int_start_frm <= 1'b0;
    @(posedge clk);

    for (int i = 0; i < NUM_ROWS; i++)
      run_row(CASES[i], i);

    $display("TESTS PASSED");
    $finish;
  end

  initial
  begin : watchdog
    int limit_ns;
    limit_ns = NUM_ROWS * (max_row_zpos() + ROW_OVH) * CLK_PERIOD;
    limit_ns = limit_ns + (RST_CYCLES + 50) * CLK_PERIOD;  // reset and margin
    #(limit_ns);
    $display("watchdog expired after %0d ns before the table was done", limit_ns);
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire
